/* filelist.f */
+incdir+include
verilog/img_pkg.sv
verilog/img_regs.sv
verilog/img_color_gain.sv
verilog/img_binarizer.sv
verilog/img_selector.sv
verilog/img_pipeline.sv
test/tb_img_pipeline.sv

/* include/tb_img_model.svh */
`ifndef TB_IMG_MODEL_SVH
`define TB_IMG_MODEL_SVH

typedef struct packed {
    logic               user;
    logic               last;
    img_pkg::out_word_t data;
} exp_beat_t;

// expected output beats, oldest first
exp_beat_t exp_q[$];

function automatic logic [img_pkg::PIX_W-1:0] model_gain(
    input logic [img_pkg::PIX_W-1:0]  pix,
    input logic [img_pkg::GAIN_W-1:0] gain
);
    int unsigned scaled;
    scaled = (int'(pix) * int'(gain)) >> img_pkg::GAIN_FRAC;
    if (scaled > 1023) begin
        return 10'h3ff;
    end
    return scaled[img_pkg::PIX_W-1:0];
endfunction

function automatic logic model_bin(
    input img_pkg::rgb_t             gained,
    input logic [img_pkg::PIX_W-1:0] th
);
    int unsigned luma;
    luma = (int'(gained.r) + 2 * int'(gained.g) + int'(gained.b)) >> 2;
    return luma >= int'(th);
endfunction

function automatic exp_beat_t model_beat(
    input img_pkg::pix_beat_t beat,
    input img_pkg::params_t   p
);
    exp_beat_t     e;
    img_pkg::rgb_t g;
    logic          bin;
    g.r    = model_gain(beat.rgb.r, p.gain_r);
    g.g    = model_gain(beat.rgb.g, p.gain_g);
    g.b    = model_gain(beat.rgb.b, p.gain_b);
    bin    = model_bin(g, p.threshold);
    e      = '0;
    e.user = beat.user;
    e.last = beat.last;
    case (p.sel)
        img_pkg::SEL_RAW:  e.data = {8'h00, beat.rgb.r[9:2], beat.rgb.g[9:2], beat.rgb.b[9:2]};
        img_pkg::SEL_GAIN: e.data = {8'h00, g.r[9:2], g.g[9:2], g.b[9:2]};
        img_pkg::SEL_BIN:  e.data = {8'h00, {24{bin}}};
        default:           e.data = '0;
    endcase
    return e;
endfunction

`endif

/* test/tb_img_pipeline.sv */
module tb_img_pipeline;

    import img_pkg::*;

    `include "tb_img_model.svh"

    localparam sel_e TB_INIT_SEL = SEL_BIN;

    logic                aclk;
    logic                rst_i;
    logic                s_valid_i;
    pix_beat_t           s_beat_i;
    logic                s_ready_o;
    logic                m_valid_o;
    logic                m_user_o;
    logic                m_last_o;
    out_word_t           m_data_o;
    logic                m_ready_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [WB_ADR_W-1:0] wb_adr_i;
    logic [WB_DAT_W-1:0] wb_dat_i;
    logic [WB_DAT_W-1:0] wb_dat_o;
    logic                wb_ack_o;

    integer      seed = 32'h78d7;
    logic [31:0] rnd_ready;
    logic        rand_ready;
    logic        lat_check;
    int          cyc_cnt;
    int          acc_q[$];
    int          lat;
    exp_beat_t   exp_e;
    params_t     shadow_m;
    params_t     active_m;
    int          pix_errs;
    int          reg_errs;
    int          flag_errs;
    int          other_errs;

    img_pipeline #(
        .INIT_SEL  (TB_INIT_SEL)
    ) img_pipeline_i (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .s_valid_i (s_valid_i),
        .s_beat_i  (s_beat_i),
        .s_ready_o (s_ready_o),
        .m_valid_o (m_valid_o),
        .m_user_o  (m_user_o),
        .m_last_o  (m_last_o),
        .m_data_o  (m_data_o),
        .m_ready_i (m_ready_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    // ------------------------------------------------------------------------
    // compare tasks and run control
    // ------------------------------------------------------------------------
    task automatic check_pix(input string name, input out_word_t got, input out_word_t exp);
        if (got !== exp) begin
            pix_errs++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [WB_DAT_W-1:0] got,
                             input logic [WB_DAT_W-1:0] exp);
        if (got !== exp) begin
            reg_errs++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d total (pix %0d, reg %0d, flag %0d, other %0d)",
                 pix_errs + reg_errs + flag_errs + other_errs,
                 pix_errs, reg_errs, flag_errs, other_errs);
    endtask

    task automatic abort_run(input string what);
        other_errs++;
        $display("Timeout at %0t: %s", $time, what);
        print_counts();
        $display("*** FAILED ***");
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // wishbone and stream drivers
    // ------------------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DAT_W-1:0] dat,
                             output logic [WB_DAT_W-1:0] rd);
        int t;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        @(posedge aclk);
        t = 1;
        while (!wb_ack_o) begin
            if (t >= 20) abort_run("no Wishbone ack");
            @(posedge aclk);
            t++;
        end
        rd = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic reg_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] rd;
        wb_access(1'b1, adr, dat, rd);
    endtask

    task automatic reg_read_check(input logic [WB_ADR_W-1:0] adr,
                                  input logic [WB_DAT_W-1:0] exp);
        logic [WB_DAT_W-1:0] rd;
        wb_access(1'b0, adr, '0, rd);
        check_reg("wb_dat_o", rd, exp);
    endtask

    task automatic set_params(input logic [GAIN_W-1:0] gr, input logic [GAIN_W-1:0] gg,
                              input logic [GAIN_W-1:0] gb, input logic [PIX_W-1:0] th,
                              input logic [1:0] sel);
        reg_write(REG_GAIN_R, 32'(gr));
        reg_write(REG_GAIN_G, 32'(gg));
        reg_write(REG_GAIN_B, 32'(gb));
        reg_write(REG_TH, 32'(th));
        reg_write(REG_SEL, 32'(sel));
    endtask

    task automatic send_beat(input pix_beat_t b, input int gap_max);
        int t;
        int gap;
        gap = (gap_max > 0) ? ($unsigned($random(seed)) % (gap_max + 1)) : 0;
        if (gap > 0) begin
            s_valid_i <= 1'b0;
            repeat (gap) @(posedge aclk);
        end
        s_valid_i <= 1'b1;
        s_beat_i  <= b;
        @(posedge aclk);
        t = 1;
        while (!s_ready_o) begin
            if (t >= 200) abort_run("input stream never ready");
            @(posedge aclk);
            t++;
        end
    endtask

    task automatic send_frame(input int lines, input int width, input int gap_max);
        pix_beat_t   b;
        logic [31:0] rnd;
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < width; p++) begin
                rnd    = $random(seed);
                b.user = (l == 0) && (p == 0);
                b.last = (p == width - 1);
                b.rgb  = rnd[29:0];
                send_beat(b, gap_max);
            end
        end
        s_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            if (t >= 2000) abort_run("output beats missing, pipeline did not drain");
            @(posedge aclk);
            t++;
        end
    endtask

    always @(posedge aclk) begin
        if (rand_ready) begin
            rnd_ready = $random(seed);
            m_ready_i <= rnd_ready[0] | rnd_ready[1];
        end else begin
            m_ready_i <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // monitor and reference tracking
    // ------------------------------------------------------------------------
    always @(posedge aclk) begin
        if (rst_i) begin
            shadow_m = '{GAIN_ONE, GAIN_ONE, GAIN_ONE, TH_DEFAULT, TB_INIT_SEL};
            active_m = shadow_m;
            cyc_cnt  = 0;
        end else begin
            if (m_valid_o && m_ready_i) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Output beat at %0t without a matching input beat", $time);
                end else begin
                    exp_e = exp_q.pop_front();
                    lat   = cyc_cnt - acc_q.pop_front();
                    check_pix("m_data_o", m_data_o, exp_e.data);
                    check_flag("m_user_o", m_user_o, exp_e.user);
                    check_flag("m_last_o", m_last_o, exp_e.last);
                    if (lat_check && lat != 3) begin
                        other_errs++;
                        $display("Output at %0t came %0d cycles after its input", $time, lat);
                    end
                end
            end
            if (s_valid_i && s_ready_o) begin
                // frame start takes the shadow values before this edge's write
                if (s_beat_i.user) active_m = shadow_m;
                exp_q.push_back(model_beat(s_beat_i, active_m));
                acc_q.push_back(cyc_cnt);
            end
            if (wb_cyc_i && wb_stb_i && !wb_ack_o && wb_we_i) begin
                case (wb_adr_i)
                    REG_GAIN_R: shadow_m.gain_r    = wb_dat_i[GAIN_W-1:0];
                    REG_GAIN_G: shadow_m.gain_g    = wb_dat_i[GAIN_W-1:0];
                    REG_GAIN_B: shadow_m.gain_b    = wb_dat_i[GAIN_W-1:0];
                    REG_TH:     shadow_m.threshold = wb_dat_i[PIX_W-1:0];
                    REG_SEL:    shadow_m.sel       = sel_e'(wb_dat_i[1:0]);
                    default:    ;
                endcase
            end
            cyc_cnt++;
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd2;
        pix_errs   = 0;
        reg_errs   = 0;
        flag_errs  = 0;
        other_errs = 0;
        rand_ready = 1'b0;
        lat_check  = 1'b0;
        rst_i     <= 1'b1;
        s_valid_i <= 1'b0;
        s_beat_i  <= '0;
        m_ready_i <= 1'b0;
        wb_cyc_i  <= 1'b0;
        wb_stb_i  <= 1'b0;
        wb_we_i   <= 1'b0;
        wb_adr_i  <= '0;
        wb_dat_i  <= '0;
        repeat (5) @(posedge aclk);
        rst_i <= 1'b0;
        @(posedge aclk);

        // reset values, readback, unmapped addresses
        reg_read_check(REG_GAIN_R, 32'(GAIN_ONE));
        reg_read_check(REG_GAIN_G, 32'(GAIN_ONE));
        reg_read_check(REG_GAIN_B, 32'(GAIN_ONE));
        reg_read_check(REG_TH, 32'(TH_DEFAULT));
        reg_read_check(REG_SEL, 32'(TB_INIT_SEL));
        reg_write(REG_GAIN_G, 32'h1a5);
        reg_read_check(REG_GAIN_G, 32'h1a5);
        reg_write(3'd6, 32'h1234);
        reg_read_check(3'd6, 32'h0);
        reg_read_check(3'd5, 32'h0);

        // gain and clip with back-pressure and input gaps
        rand_ready = 1'b1;
        repeat (3) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            set_params(rnd[11:0], rnd[23:12], rnd2[11:0], TH_DEFAULT, SEL_GAIN);
            send_frame(3, 8, 2);
            drain();
        end

        // binary and raw output, then the reserved select
        repeat (2) begin
            rnd = $random(seed);
            set_params(GAIN_ONE, rnd[21:11], GAIN_ONE, rnd[9:0], SEL_BIN);
            send_frame(2, 12, 1);
            drain();
        end
        set_params(GAIN_ONE, GAIN_ONE, GAIN_ONE, TH_DEFAULT, SEL_RAW);
        send_frame(2, 8, 1);
        set_params(GAIN_ONE, GAIN_ONE, GAIN_ONE, TH_DEFAULT, 2'd3);
        send_frame(1, 8, 1);
        drain();

        // writes in mid frame wait for the next frame start
        set_params(GAIN_ONE, GAIN_ONE, GAIN_ONE, TH_DEFAULT, SEL_RAW);
        fork
            send_frame(4, 8, 1);
            begin
                repeat (10) @(posedge aclk);
                rnd = $random(seed);
                set_params(rnd[10:0], rnd[21:11], 12'h180, TH_DEFAULT, SEL_GAIN);
            end
        join
        send_frame(2, 8, 1);
        drain();

        // fixed three cycle latency with the output always ready
        rand_ready = 1'b0;
        repeat (4) @(posedge aclk);
        lat_check = 1'b1;
        send_frame(2, 16, 0);
        drain();
        lat_check = 1'b0;

        repeat (4) @(posedge aclk);
        print_counts();
        if (pix_errs + reg_errs + flag_errs + other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/img_binarizer.sv */
module img_binarizer (
    input  logic            aclk,
    input  logic            rst_i,
    input  logic            ce_i,

    input  logic            valid_i,
    input  img_pkg::stage_t stage_i,

    output logic            valid_o,
    output img_pkg::stage_t stage_o
);

    import img_pkg::*;

    // r + 2g + b needs two extra bits
    localparam int SUM_W = PIX_W + 2;

    logic [SUM_W-1:0] luma_sum;
    logic [PIX_W-1:0] luma;
    logic             valid_q;
    stage_t           stage_d;
    stage_t           stage_q;

    assign luma_sum = SUM_W'(stage_i.gained.r)
                    + {1'b0, stage_i.gained.g, 1'b0}
                    + SUM_W'(stage_i.gained.b);
    assign luma     = luma_sum[SUM_W-1:2];

    always_comb begin
        stage_d     = stage_i;
        stage_d.bin = (luma >= stage_i.threshold);
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (ce_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce_i) begin
            stage_q <= stage_d;
        end
    end

    assign valid_o = valid_q;
    assign stage_o = stage_q;

endmodule

/* verilog/img_color_gain.sv */
module img_color_gain (
    input  logic               aclk,
    input  logic               rst_i,
    input  logic               ce_i,

    input  logic               valid_i,
    input  img_pkg::pix_beat_t beat_i,
    input  img_pkg::params_t   params_i,

    output logic               valid_o,
    output img_pkg::stage_t    stage_o
);

    import img_pkg::*;

    localparam int PROD_W  = PIX_W + GAIN_W;
    localparam int SCALE_W = PROD_W - GAIN_FRAC;

    logic   valid_q;
    stage_t stage_d;
    stage_t stage_q;

    // multiply, drop fraction, saturate at channel max
    function automatic logic [PIX_W-1:0] gain_clip(
        input logic [PIX_W-1:0]  pix,
        input logic [GAIN_W-1:0] gain
    );
        logic [PROD_W-1:0]  prod;
        logic [SCALE_W-1:0] scaled;
        prod   = pix * gain;
        scaled = prod[PROD_W-1:GAIN_FRAC];
        if (|scaled[SCALE_W-1:PIX_W]) begin
            return {PIX_W{1'b1}};
        end
        return scaled[PIX_W-1:0];
    endfunction

    always_comb begin
        stage_d.user      = beat_i.user;
        stage_d.last      = beat_i.last;
        stage_d.raw       = beat_i.rgb;
        stage_d.gained.r  = gain_clip(beat_i.rgb.r, params_i.gain_r);
        stage_d.gained.g  = gain_clip(beat_i.rgb.g, params_i.gain_g);
        stage_d.gained.b  = gain_clip(beat_i.rgb.b, params_i.gain_b);
        stage_d.bin       = 1'b0;
        // frame parameters ride along with the pixel
        stage_d.threshold = params_i.threshold;
        stage_d.sel       = params_i.sel;
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (ce_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce_i) begin
            stage_q <= stage_d;
        end
    end

    assign valid_o = valid_q;
    assign stage_o = stage_q;

endmodule

/* verilog/img_pipeline.sv */
module img_pipeline #(
    parameter img_pkg::sel_e INIT_SEL = img_pkg::SEL_GAIN
) (
    input  logic                          aclk,
    input  logic                          rst_i,

    // pixel input
    input  logic                          s_valid_i,
    input  img_pkg::pix_beat_t            s_beat_i,
    output logic                          s_ready_o,

    // packed output
    output logic                          m_valid_o,
    output logic                          m_user_o,
    output logic                          m_last_o,
    output img_pkg::out_word_t            m_data_o,
    input  logic                          m_ready_i,

    // register port
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [img_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [img_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic [img_pkg::WB_DAT_W-1:0]  wb_dat_o,
    output logic                          wb_ack_o
);

    import img_pkg::*;

    logic    ce;
    params_t params;
    logic    gain_valid;
    stage_t  gain_stage;
    logic    bin_valid;
    stage_t  bin_stage;

    assign s_ready_o = ce;

    img_regs #(
        .INIT_SEL  (INIT_SEL)
    ) img_regs_i (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .s_valid_i (s_valid_i),
        .s_user_i  (s_beat_i.user),
        .ce_i      (ce),
        .params_o  (params)
    );

    img_color_gain img_color_gain_i (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .ce_i      (ce),
        .valid_i   (s_valid_i),
        .beat_i    (s_beat_i),
        .params_i  (params),
        .valid_o   (gain_valid),
        .stage_o   (gain_stage)
    );

    img_binarizer img_binarizer_i (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .ce_i      (ce),
        .valid_i   (gain_valid),
        .stage_i   (gain_stage),
        .valid_o   (bin_valid),
        .stage_o   (bin_stage)
    );

    img_selector img_selector_i (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .valid_i   (bin_valid),
        .stage_i   (bin_stage),
        .m_ready_i (m_ready_i),
        .m_valid_o (m_valid_o),
        .m_user_o  (m_user_o),
        .m_last_o  (m_last_o),
        .m_data_o  (m_data_o),
        .ce_o      (ce)
    );

endmodule

/* verilog/img_pkg.sv */
package img_pkg;

    // ------------------------------------------------------------------------
    // widths and defaults
    // ------------------------------------------------------------------------
    localparam int PIX_W     = 10;
    localparam int OUT_W     = 8;
    localparam int GAIN_W    = 12;
    localparam int GAIN_FRAC = 8;
    localparam int WB_ADR_W  = 3;
    localparam int WB_DAT_W  = 32;

    // unity gain in 4.8 fixed point
    localparam logic [GAIN_W-1:0] GAIN_ONE   = 12'd256;
    localparam logic [PIX_W-1:0]  TH_DEFAULT = 10'd512;

    // ------------------------------------------------------------------------
    // stream and stage types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic user;
        logic last;
        rgb_t rgb;
    } pix_beat_t;

    // value 3 is reserved and blanks the output
    typedef enum logic [1:0] {
        SEL_RAW  = 2'd0,
        SEL_GAIN = 2'd1,
        SEL_BIN  = 2'd2
    } sel_e;

    typedef struct packed {
        logic [GAIN_W-1:0] gain_r;
        logic [GAIN_W-1:0] gain_g;
        logic [GAIN_W-1:0] gain_b;
        logic [PIX_W-1:0]  threshold;
        sel_e              sel;
    } params_t;

    typedef struct packed {
        logic             user;
        logic             last;
        rgb_t             raw;
        rgb_t             gained;
        logic             bin;
        logic [PIX_W-1:0] threshold;
        sel_e             sel;
    } stage_t;

    typedef enum logic [2:0] {
        REG_GAIN_R = 3'd0,
        REG_GAIN_G = 3'd1,
        REG_GAIN_B = 3'd2,
        REG_TH     = 3'd3,
        REG_SEL    = 3'd4
    } reg_addr_e;

    typedef struct packed {
        logic [7:0]       pad;
        logic [OUT_W-1:0] r;
        logic [OUT_W-1:0] g;
        logic [OUT_W-1:0] b;
    } out_word_t;

endpackage

/* verilog/img_regs.sv */
module img_regs #(
    parameter img_pkg::sel_e INIT_SEL = img_pkg::SEL_GAIN
) (
    input  logic                          aclk,
    input  logic                          rst_i,

    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [img_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [img_pkg::WB_DAT_W-1:0]  wb_dat_i,
    output logic [img_pkg::WB_DAT_W-1:0]  wb_dat_o,
    output logic                          wb_ack_o,

    input  logic                          s_valid_i,
    input  logic                          s_user_i,
    input  logic                          ce_i,
    output img_pkg::params_t              params_o
);

    import img_pkg::*;

    localparam params_t PARAMS_INIT = '{
        gain_r:    GAIN_ONE,
        gain_g:    GAIN_ONE,
        gain_b:    GAIN_ONE,
        threshold: TH_DEFAULT,
        sel:       INIT_SEL
    };

    logic                wb_req;
    reg_addr_e           wb_reg;
    logic [WB_DAT_W-1:0] rd_data;
    logic                frame_start;
    params_t             shadow;
    params_t             active;

    // ------------------------------------------------------------------------
    // wishbone classic, single cycle ack
    // ------------------------------------------------------------------------
    assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wb_reg = reg_addr_e'(wb_adr_i);

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            shadow <= PARAMS_INIT;
        end else if (wb_req && wb_we_i) begin
            case (wb_reg)
                REG_GAIN_R: shadow.gain_r    <= wb_dat_i[GAIN_W-1:0];
                REG_GAIN_G: shadow.gain_g    <= wb_dat_i[GAIN_W-1:0];
                REG_GAIN_B: shadow.gain_b    <= wb_dat_i[GAIN_W-1:0];
                REG_TH:     shadow.threshold <= wb_dat_i[PIX_W-1:0];
                REG_SEL:    shadow.sel       <= sel_e'(wb_dat_i[$bits(sel_e)-1:0]);
                default:    ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_reg)
            REG_GAIN_R: rd_data[GAIN_W-1:0]       = shadow.gain_r;
            REG_GAIN_G: rd_data[GAIN_W-1:0]       = shadow.gain_g;
            REG_GAIN_B: rd_data[GAIN_W-1:0]       = shadow.gain_b;
            REG_TH:     rd_data[PIX_W-1:0]        = shadow.threshold;
            REG_SEL:    rd_data[$bits(sel_e)-1:0] = shadow.sel;
            default:    rd_data = '0;
        endcase
    end

    assign wb_dat_o = wb_ack_o ? rd_data : '0;

    // ------------------------------------------------------------------------
    // active set, swapped at accepted frame start
    // ------------------------------------------------------------------------
    assign frame_start = s_valid_i & ce_i & s_user_i;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            active <= PARAMS_INIT;
        end else if (frame_start) begin
            active <= shadow;
        end
    end

    // first pixel of a frame sees the new values already
    assign params_o = frame_start ? shadow : active;

    a_ack_single: assert property (@(posedge aclk) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* verilog/img_selector.sv */
module img_selector (
    input  logic               aclk,
    input  logic               rst_i,

    input  logic               valid_i,
    input  img_pkg::stage_t    stage_i,

    input  logic               m_ready_i,
    output logic               m_valid_o,
    output logic               m_user_o,
    output logic               m_last_o,
    output img_pkg::out_word_t m_data_o,

    output logic               ce_o
);

    import img_pkg::*;

    out_word_t out_d;

    always_comb begin
        out_d = '0;
        case (stage_i.sel)
            SEL_RAW: begin
                out_d.r = stage_i.raw.r[PIX_W-1 -: OUT_W];
                out_d.g = stage_i.raw.g[PIX_W-1 -: OUT_W];
                out_d.b = stage_i.raw.b[PIX_W-1 -: OUT_W];
            end
            SEL_GAIN: begin
                out_d.r = stage_i.gained.r[PIX_W-1 -: OUT_W];
                out_d.g = stage_i.gained.g[PIX_W-1 -: OUT_W];
                out_d.b = stage_i.gained.b[PIX_W-1 -: OUT_W];
            end
            SEL_BIN: begin
                out_d.r = {OUT_W{stage_i.bin}};
                out_d.g = {OUT_W{stage_i.bin}};
                out_d.b = {OUT_W{stage_i.bin}};
            end
            default: out_d = '0;
        endcase
    end

    // whole pipeline advances when the output slot frees up
    assign ce_o = ~m_valid_o | m_ready_i;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            m_valid_o <= 1'b0;
        end else if (ce_o) begin
            m_valid_o <= valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (ce_o) begin
            m_user_o <= stage_i.user;
            m_last_o <= stage_i.last;
            m_data_o <= out_d;
        end
    end

    a_out_stable: assert property (@(posedge aclk) disable iff (rst_i)
        m_valid_o && !m_ready_i |=>
            m_valid_o && $stable(m_data_o) && $stable(m_user_o) && $stable(m_last_o));

endmodule
